//--- src/synth_pkg.sv
package synth_pkg;

    typedef logic [7:0]  sample_t;                // One output sample
    typedef logic [7:0]  phase_t;                 // Waveform phase
    typedef logic [5:0]  note_t;                  // Note index, 0 to 35
    typedef logic [11:0] period_t;                // Clocks per phase step
    typedef logic [7:0]  byte_t;                  // UART data byte

    typedef enum logic [1:0] {
        WAVE_TRI,
        WAVE_SAW,
        WAVE_SQUARE,
        WAVE_SINE
    } wave_e;

    // ASCII command bytes
    localparam byte_t CMD_TRI       = 8'h54;      // 'T'
    localparam byte_t CMD_SAW       = 8'h53;      // 'S'
    localparam byte_t CMD_SQUARE    = 8'h51;      // 'Q'
    localparam byte_t CMD_SINE      = 8'h57;      // 'W'
    localparam byte_t CMD_NOISE_ON  = 8'h4E;      // 'N'
    localparam byte_t CMD_NOISE_OFF = 8'h46;      // 'F'

    localparam int NOTES_PER_OCTAVE = 12;
    localparam int NUM_OCTAVES      = 3;

    // Top octave at 50 MHz, C up to B
    localparam period_t NOTE_BASE [NOTES_PER_OCTAVE] = '{
        12'd746, 12'd705, 12'd665, 12'd628,
        12'd593, 12'd559, 12'd528, 12'd498,
        12'd470, 12'd444, 12'd419, 12'd395
    };

    // One full cycle in 16 points
    localparam sample_t SINE_TABLE [16] = '{
        8'd128, 8'd176, 8'd218, 8'd246,
        8'd255, 8'd246, 8'd218, 8'd176,
        8'd128, 8'd80,  8'd38,  8'd10,
        8'd0,   8'd10,  8'd38,  8'd80
    };

    localparam logic [15:0] LFSR_SEED = 16'hACE1;

endpackage

//--- src/uart_rx.sv
module uart_rx #(
    parameter int CLKS_PER_BIT = 434
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             rx,
    output synth_pkg::byte_t rx_byte,
    output logic             rx_valid
);
    import synth_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } state_e;

    state_e           state;
    logic [CNT_W-1:0] clk_cnt;                    // Bit timer
    logic [2:0]       bit_idx;
    logic             rx_meta;
    logic             rx_sync;
    logic             rx_prev;
    logic             start_edge;

    // Two-flop synchronizer plus one flop for edge detection
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;                      // Line idles high
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign start_edge = rx_prev & ~rx_sync;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                IDLE: begin
                    clk_cnt <= '0;
                    if (start_edge) begin
                        state <= START;
                    end
                end
                START: begin
                    if (clk_cnt == HALF_BIT) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? IDLE : DATA;   // Glitch, not a start bit
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                DATA: begin
                    if (clk_cnt == FULL_BIT) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                STOP: begin
                    if (clk_cnt == FULL_BIT) begin
                        rx_valid <= rx_sync;      // Framing error drops the byte
                        state    <= IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // LSB first, shifted in at mid-bit
    always_ff @(posedge clk) begin
        if (state == DATA && clk_cnt == FULL_BIT) begin
            rx_byte <= {rx_sync, rx_byte[7:1]};
        end
    end

endmodule

//--- src/command_decoder.sv
module command_decoder (
    input  logic             clk,
    input  logic             rst_n,
    input  synth_pkg::byte_t rx_byte,
    input  logic             rx_valid,
    output synth_pkg::wave_e wave,
    output synth_pkg::note_t note,
    output logic             noise_en
);
    import synth_pkg::*;

    logic is_digit;
    logic is_letter;

    assign is_digit  = (rx_byte >= 8'h30) && (rx_byte <= 8'h39);
    assign is_letter = (rx_byte >= 8'h41) && (rx_byte <= 8'h5A);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wave     <= WAVE_TRI;
            note     <= '0;
            noise_en <= 1'b0;
        end else if (rx_valid) begin
            case (rx_byte)
                CMD_TRI:       wave     <= WAVE_TRI;
                CMD_SAW:       wave     <= WAVE_SAW;
                CMD_SQUARE:    wave     <= WAVE_SQUARE;
                CMD_SINE:      wave     <= WAVE_SINE;
                CMD_NOISE_ON:  noise_en <= 1'b1;
                CMD_NOISE_OFF: noise_en <= 1'b0;
                default: begin
                    if (is_digit) begin
                        note <= note_t'(rx_byte - 8'd48);       // '0' maps to 0
                    end else if (is_letter) begin
                        note <= note_t'(rx_byte - 8'd55);       // 'A' maps to 10
                    end
                end
            endcase
        end
    end

endmodule

//--- src/note_timer.sv
module note_timer (
    input  logic             clk,
    input  logic             rst_n,
    input  synth_pkg::note_t note,
    output logic             step
);
    import synth_pkg::*;

    logic [1:0] octave;
    logic [3:0] tone;
    logic [1:0] shift;
    period_t    period;
    period_t    cnt;

    assign octave = 2'(note / NOTES_PER_OCTAVE);
    assign tone   = 4'(note % NOTES_PER_OCTAVE);

    // Lower octaves double the top octave period
    assign shift  = 2'(NUM_OCTAVES - 1) - octave;
    assign period = NOTE_BASE[tone] << shift;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt  <= '0;
            step <= 1'b0;
        end else begin
            // >= so a shorter new period wraps at once
            if (cnt >= period - 1'b1) begin
                cnt  <= '0;
                step <= 1'b1;
            end else begin
                cnt  <= cnt + 1'b1;
                step <= 1'b0;
            end
        end
    end

endmodule

//--- src/wave_shaper.sv
module wave_shaper (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               step,
    input  synth_pkg::wave_e   wave,
    input  logic               noise_en,
    output synth_pkg::sample_t sample,
    output logic               sample_valid
);
    import synth_pkg::*;

    phase_t      phase;
    logic [15:0] lfsr;
    logic        lfsr_fb;
    sample_t     shape;
    sample_t     mixed;

    // Same taps as the 16-bit noise source, 16/14/13/11
    assign lfsr_fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    always_comb begin
        case (wave)
            WAVE_TRI: begin
                if (phase[7]) begin
                    shape = {~phase[6:0], 1'b0};        // Falling half
                end else begin
                    shape = {phase[6:0], 1'b0};         // Rising half
                end
            end
            WAVE_SAW:    shape = phase;
            WAVE_SQUARE: shape = phase[7] ? 8'd255 : 8'd0;
            WAVE_SINE:   shape = SINE_TABLE[phase[7:4]];
            default:     shape = '0;
        endcase
    end

    // Noise uses the LFSR value before this step
    assign mixed = noise_en ? (shape ^ lfsr[7:0]) : shape;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase        <= '0;
            lfsr         <= LFSR_SEED;
            sample       <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= step;
            if (step) begin
                sample <= mixed;
                phase  <= phase + 1'b1;
                lfsr   <= {lfsr[14:0], lfsr_fb};
            end
        end
    end

endmodule

//--- src/wave_synth.sv
module wave_synth #(
    parameter int CLKS_PER_BIT = 434
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               rx,
    output synth_pkg::sample_t sample,
    output logic               sample_valid
);
    import synth_pkg::*;

    byte_t rx_byte;
    logic  rx_valid;
    wave_e wave;
    note_t note;
    logic  noise_en;
    logic  step;

    uart_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_uart_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx       (rx),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    command_decoder u_command_decoder (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .wave     (wave),
        .note     (note),
        .noise_en (noise_en)
    );

    note_timer u_note_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .note  (note),
        .step  (step)
    );

    wave_shaper u_wave_shaper (
        .clk          (clk),
        .rst_n        (rst_n),
        .step         (step),
        .wave         (wave),
        .noise_en     (noise_en),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

endmodule

//--- test/tb_wave_synth.sv
module tb_wave_synth;
    timeunit 1ns;
    timeprecision 100ps;
    import synth_pkg::*;

    localparam int CLKS_PER_BIT    = 16;
    localparam int NUM_CMDS        = 45;
    localparam int SAMPLES_PER_CMD = 8;
    localparam int MAX_PERIOD      = 2984;                 // Note 0, lowest octave
    localparam int FRAME_CLKS      = 10 * CLKS_PER_BIT + 8;
    localparam int TIMEOUT =
        (NUM_CMDS + 1) * (FRAME_CLKS + SAMPLES_PER_CMD * MAX_PERIOD) + 5000;

    // Model tables, kept apart from the DUT package
    localparam period_t NOTE_REF [12] = '{
        12'd746, 12'd705, 12'd665, 12'd628, 12'd593, 12'd559,
        12'd528, 12'd498, 12'd470, 12'd444, 12'd419, 12'd395
    };
    localparam sample_t SINE_REF [16] = '{
        8'd128, 8'd176, 8'd218, 8'd246, 8'd255, 8'd246, 8'd218, 8'd176,
        8'd128, 8'd80,  8'd38,  8'd10,  8'd0,   8'd10,  8'd38,  8'd80
    };

    logic        clk;
    logic        rst_n;
    logic        rx;
    sample_t     sample;
    logic        sample_valid;

    int          seed;
    string       test_name;
    bit          in_flight;                                // UART frame on the line
    int          frame_seq;
    int          clean_count;                              // Checked samples so far
    int          cyc;
    wave_e       m_wave;
    note_t       m_note;
    logic        m_noise;
    phase_t      m_phase;
    logic [15:0] m_lfsr;
    bit          seen_pulse;
    bit          have_ref;
    int          last_seq;
    int          last_cyc;
    sample_t     exp_sample;

    wave_synth #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .rx           (rx),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_sample(input string name, input sample_t exp, input sample_t act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_period(input string name, input period_t exp, input period_t act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    function automatic sample_t shape_of(input wave_e w, input phase_t p);
        case (w)
            WAVE_TRI:    return p[7] ? sample_t'((~p) << 1) : sample_t'(p << 1);
            WAVE_SAW:    return p;
            WAVE_SQUARE: return p[7] ? 8'd255 : 8'd0;
            default:     return SINE_REF[p[7:4]];
        endcase
    endfunction

    function automatic period_t period_of(input note_t n);
        logic [3:0] tone;
        logic [1:0] oct;
        tone = 4'(n % 12);
        oct  = 2'(n / 12);
        return NOTE_REF[tone] << (2'd2 - oct);             // Double once per octave down
    endfunction

    task automatic apply_command(input byte_t b);
        if (b == CMD_TRI) m_wave = WAVE_TRI;
        else if (b == CMD_SAW) m_wave = WAVE_SAW;
        else if (b == CMD_SQUARE) m_wave = WAVE_SQUARE;
        else if (b == CMD_SINE) m_wave = WAVE_SINE;
        else if (b == CMD_NOISE_ON) m_noise = 1'b1;
        else if (b == CMD_NOISE_OFF) m_noise = 1'b0;
        else if (b >= 8'h30 && b <= 8'h39) m_note = note_t'(b - 8'h30);
        else if (b >= 8'h41 && b <= 8'h5A) m_note = note_t'(b - 8'h41 + 8'd10);
    endtask

    // Digits and capital letters all act on the settings
    function automatic bit is_command(input byte_t b);
        return (b >= 8'h30 && b <= 8'h39) || (b >= 8'h41 && b <= 8'h5A);
    endfunction

    // 8N1, LSB first, optional low stop bit
    task automatic send_frame(input byte_t b, input bit bad_stop);
        byte_t shreg;
        shreg = b;
        @(negedge clk);
        in_flight = 1'b1;
        frame_seq++;
        rx = 1'b0;
        repeat (CLKS_PER_BIT) @(negedge clk);
        repeat (8) begin
            rx    = shreg[0];
            shreg = shreg >> 1;
            repeat (CLKS_PER_BIT) @(negedge clk);
        end
        rx = ~bad_stop;
        repeat (CLKS_PER_BIT) @(negedge clk);
        rx = 1'b1;
        repeat (8) @(negedge clk);                         // Let the decoder settle
        if (!bad_stop) apply_command(b);
        in_flight = 1'b0;
    endtask

    task automatic wait_clean_samples(input int n);
        int target;
        target = clean_count + n;
        wait (clean_count >= target);
    endtask

    // Model advances on every pulse, checks only with the line idle
    always @(posedge clk) begin
        if (rst_n) begin
            cyc++;
            if (cyc > TIMEOUT) abort_run("Timeout: the sample stream stopped advancing");
            if (sample_valid) begin
                exp_sample = shape_of(m_wave, m_phase) ^ (m_noise ? m_lfsr[7:0] : 8'h00);
                if (!in_flight) begin
                    check_sample(test_name, exp_sample, sample);
                    clean_count++;
                    if (have_ref && frame_seq == last_seq) begin
                        check_period({test_name, " spacing"}, period_of(m_note),
                                     period_t'(cyc - last_cyc));
                    end
                end
                have_ref   = !in_flight;
                last_seq   = frame_seq;
                last_cyc   = cyc;
                seen_pulse = 1'b1;
                m_phase    = m_phase + 1'b1;
                m_lfsr     = {m_lfsr[14:0], m_lfsr[15] ^ m_lfsr[13] ^ m_lfsr[12] ^ m_lfsr[10]};
            end else if (!seen_pulse) begin
                check_sample("reset_idle", 8'd0, sample);
            end
        end
    end

    initial begin
        byte_t cmd;
        bit    bad;
        int    kind;
        seed        = 32'h6a715f96;
        rx          = 1'b1;
        rst_n       = 1'b0;
        in_flight   = 1'b0;
        frame_seq   = 0;
        clean_count = 0;
        cyc         = 0;
        m_wave      = WAVE_TRI;
        m_note      = '0;
        m_noise     = 1'b0;
        m_phase     = '0;
        m_lfsr      = 16'hACE1;
        seen_pulse  = 1'b0;
        have_ref    = 1'b0;
        last_seq    = 0;
        last_cyc    = 0;
        test_name   = "power_up_triangle";
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        wait_clean_samples(SAMPLES_PER_CMD);
        for (int i = 0; i < NUM_CMDS; i++) begin
            bad  = 1'b0;
            kind = (i < 4) ? 5 + i : int'($unsigned($random(seed)) % 5);
            case (kind)
                0: begin
                    test_name = "wave_cmd";
                    case ($unsigned($random(seed)) % 4)
                        0:       cmd = CMD_TRI;
                        1:       cmd = CMD_SAW;
                        2:       cmd = CMD_SQUARE;
                        default: cmd = CMD_SINE;
                    endcase
                end
                1: begin
                    test_name = "note_cmd";
                    kind = int'($unsigned($random(seed)) % 36);
                    cmd  = (kind < 10) ? byte_t'(8'h30 + kind) : byte_t'(8'h41 + kind - 10);
                end
                2: begin
                    test_name = "noise_cmd";
                    cmd = ($random(seed) & 1) ? CMD_NOISE_ON : CMD_NOISE_OFF;
                end
                3: begin
                    test_name = "random_byte";
                    cmd = byte_t'($random(seed));
                    while (is_command(cmd)) begin
                        cmd = byte_t'($random(seed));
                    end
                end
                4: begin
                    test_name = "bad_stop";
                    cmd = m_noise ? CMD_NOISE_OFF : CMD_NOISE_ON;  // Would flip noise if taken
                    bad = 1'b1;
                end
                5: begin
                    test_name = "noise_on";
                    cmd = CMD_NOISE_ON;
                end
                6: begin
                    test_name = "sine_noise";
                    cmd = CMD_SINE;
                end
                7: begin
                    test_name = "noise_off";
                    cmd = CMD_NOISE_OFF;
                end
                default: begin
                    test_name = "note_high";
                    cmd = 8'h5A;                           // 'Z', top note
                end
            endcase
            send_frame(cmd, bad);
            wait_clean_samples(SAMPLES_PER_CMD);
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- wave_synth.f
src/synth_pkg.sv
src/uart_rx.sv
src/command_decoder.sv
src/note_timer.sv
src/wave_shaper.sv
src/wave_synth.sv
test/tb_wave_synth.sv

//--- Makefile
# Verilator build for the wave_synth testbench
VERILATOR ?= verilator
TOP       ?= tb_wave_synth
FILELIST  ?= wave_synth.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary -j 0 --timescale $(TIMESCALE)

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# A $fatal in the testbench gives a non-zero exit status
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)
